// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = alu_top_tb
FILELIST  = alu_exec.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qxF "$(PASS_MSG)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

// ==== alu_exec.f ====
+incdir+hdl
hdl/alu_pkg.sv
hdl/rf_read_if.sv
hdl/reg_file.sv
hdl/operand_sel.sv
hdl/alu.sv
hdl/writeback_stage.sv
hdl/alu_top.sv
verif/alu_top_assertions.sv
verif/alu_top_tb.sv

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"
`default_nettype none

module alu
    import alu_pkg::*;
(
    input  logic [`DATA_WIDTH-1:0] op1_i,  // Operand 1
    input  logic [`DATA_WIDTH-1:0] op2_i,  // Operand 2
    input  alu_op_e                ctrl_i, // Operation select
    output logic [`DATA_WIDTH-1:0] out_o,  // Result
    output logic                   eq_o    // Result is zero
);

    logic [4:0] shamt;  // Shift amount, low bits of op2
    logic       lt_s;   // Signed compare
    logic       lt_u;   // Unsigned compare

    assign shamt = op2_i[4:0];
    assign lt_s  = $signed(op1_i) < $signed(op2_i);
    assign lt_u  = op1_i < op2_i;

    always_comb begin
        case (ctrl_i)
            ALU_ADD: begin
                out_o = op1_i + op2_i;
            end
            ALU_SUB: begin
                out_o = op1_i - op2_i; // Zero on equal operands
            end
            ALU_AND: begin
                out_o = op1_i & op2_i;
            end
            ALU_OR: begin
                out_o = op1_i | op2_i;
            end
            ALU_XOR: begin
                out_o = op1_i ^ op2_i;
            end
            ALU_SLL: begin
                out_o = op1_i << shamt;
            end
            ALU_SRL: begin
                out_o = op1_i >> shamt; // Zero fill
            end
            ALU_SRA: begin
                out_o = $signed(op1_i) >>> shamt; // Sign fill
            end
            ALU_SLT: begin
                out_o = {{(`DATA_WIDTH-1){1'b0}}, lt_s};
            end
            ALU_SLTU: begin
                out_o = {{(`DATA_WIDTH-1){1'b0}}, lt_u};
            end
            default: begin
                out_o = '0; // Unused codes
            end
        endcase
    end

    // Branch compare uses SUB and checks this flag
    assign eq_o = (out_o == '0);

endmodule

`default_nettype wire

// ==== hdl/alu_macros.svh ====
`default_nettype none

`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

`define ADDR_WIDTH 5  // Register address bits
`define DATA_WIDTH 32 // Datapath width
`define REG_COUNT  32 // Architectural registers incl. x0

`endif

`default_nettype wire

// ==== hdl/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    // ALU operation select, matches the 4-bit alu_ctrl_i encoding
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0, // op1 + op2
        ALU_SUB  = 4'd1, // op1 - op2
        ALU_AND  = 4'd2, // Bitwise and
        ALU_OR   = 4'd3, // Bitwise or
        ALU_XOR  = 4'd4, // Bitwise xor
        ALU_SLL  = 4'd5, // Logical left shift
        ALU_SRL  = 4'd6, // Logical right shift
        ALU_SRA  = 4'd7, // Arithmetic right shift
        ALU_SLT  = 4'd8, // Signed less than
        ALU_SLTU = 4'd9  // Unsigned less than
    } alu_op_e;          // Codes 10..15 give zero

    // Result source for register writeback
    typedef enum logic [1:0] {
        WB_ALU = 2'd0, // ALU output
        WB_MEM = 2'd1, // Memory read value
        WB_PC4 = 2'd2  // Return address for jumps
    } wb_src_e;

endpackage

`default_nettype wire

// ==== hdl/alu_top.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"
`default_nettype none

module alu_top
    import alu_pkg::*;
(
    input  logic                   clk_i,           // Clock
    input  logic                   rst_i,           // Sync reset
    input  logic [`ADDR_WIDTH-1:0] rs1_i,           // Source register 1
    input  logic [`ADDR_WIDTH-1:0] rs2_i,           // Source register 2
    input  logic [`ADDR_WIDTH-1:0] rd_i,            // Destination register
    input  logic                   reg_write_i,     // Register write enable
    input  logic                   reg_write_src_i, // 0 ALU, 1 memory
    input  logic                   alu_src_i,       // 0 rs2, 1 immediate
    input  logic                   jstore_i,        // Jump, write PC+4
    input  logic [`DATA_WIDTH-1:0] imm_op_i,        // Immediate value
    input  logic [`DATA_WIDTH-1:0] mem_read_val_i,  // Memory read value
    input  logic [3:0]             alu_ctrl_i,      // ALU operation select
    input  logic [31:0]            pc_plus4_i,      // Return address
    output logic                   eq_o,            // ALU result is zero
    output logic [`DATA_WIDTH-1:0] alu_out_o,       // ALU result
    output logic [`DATA_WIDTH-1:0] rs1_val_o,       // Value at rs1
    output logic [`DATA_WIDTH-1:0] rs2_val_o        // Value at rs2, store data
);

    logic                   wb_we;   // Pending write enable
    logic [`ADDR_WIDTH-1:0] wb_addr; // Pending destination
    logic [`DATA_WIDTH-1:0] wb_data; // Pending result
    logic [`DATA_WIDTH-1:0] op1;     // ALU operand 1
    logic [`DATA_WIDTH-1:0] op2;     // ALU operand 2

    rf_read_if rf_bus (); // Read ports between operand_sel and reg_file

    reg_file u_reg_file (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .rd_port (rf_bus.responder),
        .we_i    (wb_we),   // Written one cycle after capture
        .wa_i    (wb_addr),
        .wd_i    (wb_data)
    );

    operand_sel u_operand_sel (
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .imm_op_i   (imm_op_i),
        .alu_src_i  (alu_src_i),
        .rf         (rf_bus.requester),
        .fwd_we_i   (wb_we),   // Same path as the write port
        .fwd_addr_i (wb_addr),
        .fwd_data_i (wb_data),
        .rs1_val_o  (rs1_val_o),
        .rs2_val_o  (rs2_val_o),
        .op1_o      (op1),
        .op2_o      (op2)
    );

    alu u_alu (
        .op1_i  (op1),
        .op2_i  (op2),
        .ctrl_i (alu_op_e'(alu_ctrl_i)), // Raw code to enum
        .out_o  (alu_out_o),
        .eq_o   (eq_o)
    );

    writeback_stage u_writeback_stage (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .rd_i            (rd_i),
        .reg_write_i     (reg_write_i),
        .reg_write_src_i (reg_write_src_i),
        .jstore_i        (jstore_i),
        .alu_out_i       (alu_out_o),
        .mem_read_val_i  (mem_read_val_i),
        .pc_plus4_i      (pc_plus4_i),
        .wb_we_o         (wb_we),
        .wb_addr_o       (wb_addr),
        .wb_data_o       (wb_data)
    );

endmodule

`default_nettype wire

// ==== hdl/operand_sel.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"
`default_nettype none

module operand_sel (
    input  logic [`ADDR_WIDTH-1:0] rs1_i,      // Source register 1
    input  logic [`ADDR_WIDTH-1:0] rs2_i,      // Source register 2
    input  logic [`DATA_WIDTH-1:0] imm_op_i,   // Immediate operand
    input  logic                   alu_src_i,  // 1 selects immediate for op2
    rf_read_if.requester           rf,         // Register file reads
    input  logic                   fwd_we_i,   // Writeback enable
    input  logic [`ADDR_WIDTH-1:0] fwd_addr_i, // Writeback destination
    input  logic [`DATA_WIDTH-1:0] fwd_data_i, // Writeback result
    output logic [`DATA_WIDTH-1:0] rs1_val_o,  // Resolved rs1 value
    output logic [`DATA_WIDTH-1:0] rs2_val_o,  // Resolved rs2 value, store data
    output logic [`DATA_WIDTH-1:0] op1_o,      // ALU operand 1
    output logic [`DATA_WIDTH-1:0] op2_o       // ALU operand 2
);

    logic fwd_hit1; // rs1 matches pending write
    logic fwd_hit2; // rs2 matches pending write

    assign rf.ad1 = rs1_i; // Straight to the array
    assign rf.ad2 = rs2_i;

    // The pending writeback has not reached the array yet, so a matching
    // read must take its data instead of the stale stored value
    assign fwd_hit1 = fwd_we_i && (fwd_addr_i == rs1_i) && (rs1_i != '0);
    assign fwd_hit2 = fwd_we_i && (fwd_addr_i == rs2_i) && (rs2_i != '0);

    always_comb begin
        rs1_val_o = rf.rd1; // Stored value by default
        if (fwd_hit1) begin
            rs1_val_o = fwd_data_i; // Bypass from writeback
        end
    end

    always_comb begin
        rs2_val_o = rf.rd2;
        if (fwd_hit2) begin
            rs2_val_o = fwd_data_i;
        end
    end

    assign op1_o = rs1_val_o;                        // Always a register
    assign op2_o = alu_src_i ? imm_op_i : rs2_val_o; // Imm or register

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"
`default_nettype none

module reg_file (
    input  logic                   clk_i,   // Clock
    input  logic                   rst_i,   // Sync reset clears all entries
    rf_read_if.responder           rd_port, // Two async read ports
    input  logic                   we_i,    // Write enable
    input  logic [`ADDR_WIDTH-1:0] wa_i,    // Write address
    input  logic [`DATA_WIDTH-1:0] wd_i     // Write data
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT]; // Storage array
    logic                   wr_en;             // Qualified write strobe

    assign wr_en = we_i && (wa_i != '0); // x0 is never written

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0; // Every entry back to zero
            end
        end else if (wr_en) begin
            regs[wa_i] <= wd_i;
        end
    end

    // Reads are combinational; address 0 is forced to zero regardless of
    // array contents
    assign rd_port.rd1 = (rd_port.ad1 == '0) ? '0 : regs[rd_port.ad1]; // Port 1
    assign rd_port.rd2 = (rd_port.ad2 == '0) ? '0 : regs[rd_port.ad2]; // Port 2

endmodule

`default_nettype wire

// ==== hdl/rf_read_if.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"
`default_nettype none

interface rf_read_if;

    logic [`ADDR_WIDTH-1:0] ad1; // Read address, port 1
    logic [`ADDR_WIDTH-1:0] ad2; // Read address, port 2
    logic [`DATA_WIDTH-1:0] rd1; // Read data, port 1
    logic [`DATA_WIDTH-1:0] rd2; // Read data, port 2

    modport requester (          // Operand selection side
        output ad1, ad2,
        input  rd1, rd2
    );

    modport responder (          // Register file side
        input  ad1, ad2,
        output rd1, rd2
    );

endinterface

`default_nettype wire

// ==== hdl/writeback_stage.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"
`default_nettype none

module writeback_stage
    import alu_pkg::*;
(
    input  logic                   clk_i,           // Clock
    input  logic                   rst_i,           // Sync reset
    input  logic [`ADDR_WIDTH-1:0] rd_i,            // Destination register
    input  logic                   reg_write_i,     // Register write enable
    input  logic                   reg_write_src_i, // 1 selects memory value
    input  logic                   jstore_i,        // Jump, write PC+4
    input  logic [`DATA_WIDTH-1:0] alu_out_i,       // ALU result
    input  logic [`DATA_WIDTH-1:0] mem_read_val_i,  // Load data
    input  logic [31:0]            pc_plus4_i,      // Return address
    output logic                   wb_we_o,         // Registered enable
    output logic [`ADDR_WIDTH-1:0] wb_addr_o,       // Registered destination
    output logic [`DATA_WIDTH-1:0] wb_data_o        // Registered result
);

    wb_src_e                wb_src;   // Decoded source
    logic [`DATA_WIDTH-1:0] wb_value; // Selected result

    always_comb begin
        if (jstore_i) begin
            wb_src = WB_PC4; // Jump wins over load
        end else if (reg_write_src_i) begin
            wb_src = WB_MEM;
        end else begin
            wb_src = WB_ALU;
        end
    end

    always_comb begin
        case (wb_src)
            WB_PC4:  wb_value = pc_plus4_i;
            WB_MEM:  wb_value = mem_read_val_i;
            default: wb_value = alu_out_i;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_we_o <= 1'b0; // No write pending after reset
        end else begin
            wb_we_o <= reg_write_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_addr_o <= rd_i;     // Payload, qualified by wb_we_o
        wb_data_o <= wb_value;
    end

endmodule

`default_nettype wire

// ==== verif/alu_top_assertions.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"
`default_nettype none

module alu_top_assertions
    import alu_pkg::*;
(
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   wb_we_i,    // Pending write enable
    input logic [`ADDR_WIDTH-1:0] wb_addr_i,  // Pending destination
    input logic [`ADDR_WIDTH-1:0] rs1_i,
    input logic [`ADDR_WIDTH-1:0] rs2_i,
    input logic [`DATA_WIDTH-1:0] rs1_val_i,
    input logic [`DATA_WIDTH-1:0] rs2_val_i,
    input logic [3:0]             alu_ctrl_i, // Raw ALU opcode
    input logic                   alu_src_i,  // Immediate select
    input logic                   eq_i
);

    wb_idle_after_reset: assert property (@(posedge clk_i) rst_i |=> !wb_we_i)
        else $error("Writeback enable high in the cycle after reset");

    x0_reads_zero: assert property (@(posedge clk_i) disable iff (rst_i)
        ((rs1_i != '0) || (rs1_val_i == '0)) && ((rs2_i != '0) || (rs2_val_i == '0)))
        else $error("Read of x0 returned nonzero");

    // Register SUB raises the flag exactly on equal operands
    eq_on_equal_sub: assert property (@(posedge clk_i) disable iff (rst_i)
        ((alu_ctrl_i == ALU_SUB) && !alu_src_i) |-> (eq_i == (rs1_val_i == rs2_val_i)))
        else $error("Zero flag disagrees with operand equality on SUB");

    // A write aimed at x0 must leave it reading zero afterwards
    x0_write_ignored: assert property (@(posedge clk_i) disable iff (rst_i)
        (wb_we_i && (wb_addr_i == '0)) |=>
            (((rs1_i != '0) || (rs1_val_i == '0)) && ((rs2_i != '0) || (rs2_val_i == '0))))
        else $error("Write to x0 changed a later read");

endmodule

bind alu_top alu_top_assertions u_alu_top_assertions (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wb_we_i    (wb_we),
    .wb_addr_i  (wb_addr),
    .rs1_i      (rs1_i),
    .rs2_i      (rs2_i),
    .rs1_val_i  (rs1_val_o),
    .rs2_val_i  (rs2_val_o),
    .alu_ctrl_i (alu_ctrl_i),
    .alu_src_i  (alu_src_i),
    .eq_i       (eq_o)
);

`default_nettype wire

// ==== verif/alu_top_tb.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"
`default_nettype none

module alu_top_tb
    import alu_pkg::*;
();

    localparam int NUM_INSTR  = 2000; // Random instructions
    localparam int SWEEP_LEN  = 16;   // Post-reset read sweep, two regs per cycle
    localparam int TIMEOUT_NS = (NUM_INSTR + SWEEP_LEN + 8) * 10 + 500; // Bound plus margin

    logic                   clk = 1'b0;
    logic                   rst;
    logic [`ADDR_WIDTH-1:0] rs1;
    logic [`ADDR_WIDTH-1:0] rs2;
    logic [`ADDR_WIDTH-1:0] rd;
    logic                   reg_write;
    logic                   reg_write_src;
    logic                   alu_src;
    logic                   jstore;
    logic [`DATA_WIDTH-1:0] imm_op;
    logic [`DATA_WIDTH-1:0] mem_read_val;
    logic [3:0]             alu_ctrl;
    logic [31:0]            pc_plus4;
    logic                   eq;
    logic [`DATA_WIDTH-1:0] alu_out;
    logic [`DATA_WIDTH-1:0] rs1_val;
    logic [`DATA_WIDTH-1:0] rs2_val;

    logic [`DATA_WIDTH-1:0] model_regs [`REG_COUNT]; // Expected register contents
    logic                   pend_we;                 // Model writeback enable
    logic [`ADDR_WIDTH-1:0] pend_addr;               // Model writeback destination
    logic [`DATA_WIDTH-1:0] pend_data;               // Model writeback value
    logic [`DATA_WIDTH-1:0] wb_next;                 // Value captured this edge
    logic [`DATA_WIDTH-1:0] exp_rs1;
    logic [`DATA_WIDTH-1:0] exp_rs2;
    logic [`DATA_WIDTH-1:0] exp_alu;
    integer                 seed;                    // Stimulus seed
    int                     error_count = 0;

    alu_top alu_top_i (
        .clk_i           (clk),
        .rst_i           (rst),
        .rs1_i           (rs1),
        .rs2_i           (rs2),
        .rd_i            (rd),
        .reg_write_i     (reg_write),
        .reg_write_src_i (reg_write_src),
        .alu_src_i       (alu_src),
        .jstore_i        (jstore),
        .imm_op_i        (imm_op),
        .mem_read_val_i  (mem_read_val),
        .alu_ctrl_i      (alu_ctrl),
        .pc_plus4_i      (pc_plus4),
        .eq_o            (eq),
        .alu_out_o       (alu_out),
        .rs1_val_o       (rs1_val),
        .rs2_val_o       (rs2_val)
    );

    always #5 clk = ~clk; // 10 ns period

    // Expected ALU result, written from the opcode table
    function automatic logic [31:0] alu_ref(input logic [31:0] a, input logic [31:0] b,
                                            input logic [3:0] code);
        logic [4:0]  sh;
        logic [31:0] fill;
        sh   = b[4:0];                                     // Low five bits only
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;     // Sign bits shifted in
        case (alu_op_e'(code))
            ALU_ADD:  alu_ref = a + b;
            ALU_SUB:  alu_ref = a - b;
            ALU_AND:  alu_ref = a & b;
            ALU_OR:   alu_ref = a | b;
            ALU_XOR:  alu_ref = a ^ b;
            ALU_SLL:  alu_ref = a << sh;
            ALU_SRL:  alu_ref = a >> sh;
            ALU_SRA:  alu_ref = (a >> sh) | fill;
            ALU_SLT:  alu_ref = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            ALU_SLTU: alu_ref = (a < b) ? 32'd1 : 32'd0;
            default:  alu_ref = 32'd0;                     // Codes 10..15
        endcase
    endfunction

    // Writeback source rule, jump before load before ALU
    function automatic logic [31:0] wb_ref(input logic js, input logic mem_sel,
                                           input logic [31:0] alu_v, input logic [31:0] mem_v,
                                           input logic [31:0] pc4_v);
        wb_src_e src;
        if (js) begin
            src = WB_PC4;
        end else if (mem_sel) begin
            src = WB_MEM;
        end else begin
            src = WB_ALU;
        end
        case (src)
            WB_PC4:  wb_ref = pc4_v;
            WB_MEM:  wb_ref = mem_v;
            default: wb_ref = alu_v;
        endcase
    endfunction

    // Register read seen by the instruction in execute
    function automatic logic [31:0] model_read(input logic [`ADDR_WIDTH-1:0] addr);
        if (addr == '0) begin
            model_read = '0;                     // x0 hardwired
        end else if (pend_we && (pend_addr == addr)) begin
            model_read = pend_data;              // Not yet in the array
        end else begin
            model_read = model_regs[addr];
        end
    endfunction

    function automatic logic [31:0] model_alu();
        logic [31:0] op2;
        op2       = alu_src ? imm_op : model_read(rs2);
        model_alu = alu_ref(model_read(rs1), op2, alu_ctrl);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s expected %h actual %h", $time, name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Model state follows the DUT edge, inputs are stable here
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                model_regs[i] = '0;
            end
            pend_we = 1'b0;
        end else begin
            wb_next = wb_ref(jstore, reg_write_src, model_alu(), mem_read_val, pc_plus4);
            if (pend_we && (pend_addr != '0)) begin
                model_regs[pend_addr] = pend_data; // Write lands one cycle late
            end
            pend_we   = reg_write;
            pend_addr = rd;
            pend_data = wb_next;
        end
    end

    // Mid-cycle compare, outputs settled since the 1 ns drive
    always @(negedge clk) begin
        if (!rst) begin
            exp_rs1 = model_read(rs1);
            exp_rs2 = model_read(rs2);
            exp_alu = model_alu();
            check_value("rs1_val_o", exp_rs1, rs1_val);
            check_value("rs2_val_o", exp_rs2, rs2_val);
            check_value("alu_out_o", exp_alu, alu_out);
            check_value("eq_o", {31'd0, exp_alu == '0}, {31'd0, eq});
        end
    end

    task automatic drive_idle();
        rs1           = '0;
        rs2           = '0;
        rd            = '0;
        reg_write     = 1'b0;
        reg_write_src = 1'b0;
        alu_src       = 1'b0;
        jstore        = 1'b0;
        imm_op        = '0;
        mem_read_val  = '0;
        alu_ctrl      = 4'd0;
        pc_plus4      = 32'd0;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] v;
        r             = $random(seed);
        v             = $random(seed);
        rs1           = {3'b000, r[1:0]};        // Only x0..x3, hazards are common
        rs2           = {3'b000, r[3:2]};
        rd            = {3'b000, r[5:4]};
        alu_ctrl      = r[9:6];                  // Includes undefined codes
        alu_src       = r[10];
        reg_write     = r[11] | r[12];           // Mostly writing
        reg_write_src = r[13] & r[14];
        jstore        = r[15] & r[16] & r[17];
        imm_op        = r[18] ? v : {27'd0, v[4:0]}; // Small values hit shifts and zero
        mem_read_val  = $random(seed);
        v             = $random(seed);
        pc_plus4      = {v[31:2], 2'b00};
    endtask

    initial begin
        seed = 32'h8a07_121d;
        rst  = 1'b1;
        drive_idle();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < SWEEP_LEN; i++) begin
            drive_idle();
            rs1 = i[4:0];          // Every register right after reset
            rs2 = i[4:0] | 5'h10;
            @(posedge clk);
            #1;
        end
        for (int n = 0; n < NUM_INSTR; n++) begin
            drive_random();
            @(posedge clk);
            #1;
        end
        drive_idle();
        repeat (2) @(posedge clk);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the test did not finish within %0d ns", TIMEOUT_NS);
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
